/* hdl/dcache_pkg.sv */
package dcache_pkg;

	// Cache geometry, one word per line.
	localparam int CACHE_INDEX_BITS = 4;
	localparam int CACHE_LINES = 1 << CACHE_INDEX_BITS;

	// Main memory size in words and its wait states.
	localparam int MEM_ADDR_BITS = 8;
	localparam int MEM_LATENCY = 3;

	typedef struct packed {
		logic rw;
		logic flush;
		logic cacheable;
		logic [31:0] address;
		logic [31:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		logic rw;
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

	// Tag holds the whole word address, so the index bits take part in the compare.
	typedef struct packed {
		logic valid;
		logic dirty;
		logic [29:0] tag;
		logic [31:0] data;
	} cache_entry_t;

	typedef enum logic [3:0] {
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT,
		INITIALIZE
	} ctrl_state_t;

endpackage

/* hdl/line_ram.sv */
module line_ram #(
	parameter type T = logic [31:0],
	parameter int DEPTH = 16
) (
	input logic i_clock,
	input logic i_write,
	input logic [$clog2(DEPTH)-1:0] i_index,
	input T i_wdata,
	output T o_rdata
);

	T mem [DEPTH];

	// Registered read, one cycle from index to data.
	// A write returns the new word, so the output always shows the
	// current contents of the line last addressed.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wdata;
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= mem[i_index];
		end
	end

endmodule

/* hdl/dcache_ctrl.sv */
module dcache_ctrl (
	input logic i_clock,
	input logic i_reset,

	// CPU side.
	input logic i_request,
	input dcache_pkg::cpu_req_t i_cpu_req,
	output logic o_ready,
	output logic [31:0] o_rdata,

	// Bus side.
	output logic o_bus_request,
	output dcache_pkg::bus_req_t o_bus_req,
	input logic i_bus_ready,
	input logic [31:0] i_bus_rdata,

	// Line RAM.
	output logic o_ram_write,
	output logic [dcache_pkg::CACHE_INDEX_BITS-1:0] o_ram_index,
	output dcache_pkg::cache_entry_t o_ram_wdata,
	input dcache_pkg::cache_entry_t i_ram_rdata
);

	import dcache_pkg::*;

	ctrl_state_t state;
	logic [CACHE_INDEX_BITS:0] line_count;
	logic [CACHE_INDEX_BITS-1:0] wr_index;

	logic [CACHE_INDEX_BITS-1:0] req_index;
	logic [29:0] req_tag;
	logic entry_hit;
	logic victim_dirty;
	cache_entry_t write_entry;
	bus_req_t victim_req;

	assign req_index = i_cpu_req.address[CACHE_INDEX_BITS+1:2];
	assign req_tag = i_cpu_req.address[31:2];
	assign entry_hit = i_ram_rdata.valid && (i_ram_rdata.tag == req_tag);
	assign victim_dirty = i_ram_rdata.valid && i_ram_rdata.dirty && !entry_hit;
	assign write_entry = '{valid: 1'b1, dirty: 1'b1, tag: req_tag, data: i_cpu_req.wdata};
	assign victim_req = '{rw: 1'b1, address: {i_ram_rdata.tag, 2'b00}, wdata: i_ram_rdata.data};

	// A pending write owns the RAM port, flush walks by counter,
	// otherwise the request address selects the line.
	always_comb begin
		if (o_ram_write)
			o_ram_index = wr_index;
		else if (state inside {FLUSH_SETUP, FLUSH_CHECK, FLUSH_WRITE})
			o_ram_index = line_count[CACHE_INDEX_BITS-1:0];
		else
			o_ram_index = req_index;
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= INITIALIZE;
			line_count <= '0;
			o_ready <= 1'b0;
			o_bus_request <= 1'b0;
			o_ram_write <= 1'b0;
		end else begin
			o_ready <= 1'b0;
			o_ram_write <= 1'b0;

			case (state)
				IDLE: begin
					if (i_request && !o_ready) begin
						if (i_cpu_req.flush) begin
							line_count <= '0;
							state <= FLUSH_SETUP;
						end else if (i_cpu_req.cacheable) begin
							// The entry read last cycle may already be ours.
							if (entry_hit) begin
								if (i_cpu_req.rw) begin
									o_ram_write <= 1'b1;
									wr_index <= req_index;
									o_ram_wdata <= write_entry;
								end else begin
									o_rdata <= i_ram_rdata.data;
								end
								o_ready <= 1'b1;
							end else if (i_cpu_req.rw) begin
								state <= WRITE_SETUP;
							end else begin
								state <= READ_SETUP;
							end
						end else begin
							o_bus_req <= '{rw: i_cpu_req.rw, address: i_cpu_req.address,
								wdata: i_cpu_req.wdata};
							o_bus_request <= 1'b1;
							state <= PASS_THROUGH;
						end
					end
				end

				// ======================================================================
				// Flush
				// ======================================================================

				FLUSH_SETUP: begin
					// Hold off while the previous clean entry is written.
					if (!o_ram_write) begin
						if (line_count < CACHE_LINES) begin
							state <= FLUSH_CHECK;
						end else begin
							line_count <= '0;
							o_ready <= 1'b1;
							state <= IDLE;
						end
					end
				end

				FLUSH_CHECK: begin
					if (i_ram_rdata.valid && i_ram_rdata.dirty) begin
						o_bus_req <= victim_req;
						o_bus_request <= 1'b1;
						state <= FLUSH_WRITE;
					end else begin
						line_count <= line_count + 1'b1;
						state <= FLUSH_SETUP;
					end
				end

				FLUSH_WRITE: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_ram_write <= 1'b1;
						wr_index <= line_count[CACHE_INDEX_BITS-1:0];
						o_ram_wdata <= '{valid: 1'b1, dirty: 1'b0, tag: o_bus_req.address[31:2],
							data: o_bus_req.wdata};
						line_count <= line_count + 1'b1;
						state <= FLUSH_SETUP;
					end
				end

				// Uncacheable access goes straight to the bus.
				PASS_THROUGH: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				// ======================================================================
				// Write
				// ======================================================================

				WRITE_SETUP: begin
					if (victim_dirty) begin
						o_bus_req <= victim_req;
						o_bus_request <= 1'b1;
						state <= WRITE_WAIT;
					end else begin
						o_ram_write <= 1'b1;
						wr_index <= req_index;
						o_ram_wdata <= write_entry;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				// Once the victim is in memory the line takes the new word.
				WRITE_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_ram_write <= 1'b1;
						wr_index <= req_index;
						o_ram_wdata <= write_entry;
						o_ready <= 1'b1;
						state <= IDLE;
					end
				end

				// ======================================================================
				// Read
				// ======================================================================

				READ_SETUP: begin
					if (entry_hit) begin
						o_rdata <= i_ram_rdata.data;
						o_ready <= 1'b1;
						state <= IDLE;
					end else if (victim_dirty) begin
						o_bus_req <= victim_req;
						o_bus_request <= 1'b1;
						state <= READ_WB_WAIT;
					end else begin
						o_bus_req <= '{rw: 1'b0, address: i_cpu_req.address, wdata: '0};
						o_bus_request <= 1'b1;
						state <= READ_BUS_WAIT;
					end
				end

				READ_WB_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_bus_req <= '{rw: 1'b0, address: i_cpu_req.address, wdata: '0};
						state <= READ_BUS_WAIT;
					end
				end

				// Request is raised again after the write-back gap.
				READ_BUS_WAIT: begin
					if (i_bus_ready) begin
						o_bus_request <= 1'b0;
						o_ram_write <= 1'b1;
						wr_index <= req_index;
						o_ram_wdata <= '{valid: 1'b1, dirty: 1'b0, tag: req_tag,
							data: i_bus_rdata};
						o_rdata <= i_bus_rdata;
						o_ready <= 1'b1;
						state <= IDLE;
					end else begin
						o_bus_request <= 1'b1;
					end
				end

				// Invalidate every line.
				INITIALIZE: begin
					if (!line_count[CACHE_INDEX_BITS]) begin
						o_ram_write <= 1'b1;
						wr_index <= line_count[CACHE_INDEX_BITS-1:0];
						o_ram_wdata <= '0;
						line_count <= line_count + 1'b1;
					end else begin
						line_count <= '0;
						state <= IDLE;
					end
				end

				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Bus request is held until the slave answers.
	a_bus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request && !i_bus_ready |=> o_bus_request);

	a_ready_req: assert property (@(posedge i_clock) disable iff (i_reset)
		$rose(o_ready) |-> i_request);

	// A line write comes with a completion, a flush step or initialization.
	a_ram_write: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ram_write |-> o_ready || (state inside {FLUSH_SETUP, INITIALIZE}));

endmodule

/* hdl/main_memory.sv */
module main_memory (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input dcache_pkg::bus_req_t i_bus_req,
	output logic o_bus_ready,
	output logic [31:0] o_bus_rdata
);

	import dcache_pkg::*;

	logic [$clog2(MEM_LATENCY+1)-1:0] wait_count;
	logic served;
	logic last_wait;
	logic mem_write;

	// Last wait cycle of a request not yet answered.
	assign last_wait = i_bus_request && !served && (wait_count == MEM_LATENCY);
	assign mem_write = last_wait && i_bus_req.rw;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
			served <= 1'b0;
			o_bus_ready <= 1'b0;
		end else begin
			o_bus_ready <= 1'b0;
			if (!i_bus_request) begin
				// Ready for the next request once this one drops.
				served <= 1'b0;
				wait_count <= '0;
			end else if (last_wait) begin
				o_bus_ready <= 1'b1;
				served <= 1'b1;
				wait_count <= '0;
			end else if (!served) begin
				wait_count <= wait_count + 1'b1;
			end
		end
	end

	line_ram #(
		.T(logic [31:0]),
		.DEPTH(1 << MEM_ADDR_BITS)
	) word_ram_i (
		.i_clock(i_clock),
		.i_write(mem_write),
		.i_index(i_bus_req.address[MEM_ADDR_BITS+1:2]),
		.i_wdata(i_bus_req.wdata),
		.o_rdata(o_bus_rdata)
	);

	a_ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_ready |-> i_bus_request ##1 !o_bus_ready);

endmodule

/* hdl/dcache_top.sv */
module dcache_top (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input dcache_pkg::cpu_req_t i_cpu_req,
	output logic o_ready,
	output logic [31:0] o_rdata
);

	import dcache_pkg::*;

	// Bus between the controller and main memory.
	logic bus_request;
	bus_req_t bus_req;
	logic bus_ready;
	logic [31:0] bus_rdata;

	// Cache store port.
	logic ram_write;
	logic [CACHE_INDEX_BITS-1:0] ram_index;
	cache_entry_t ram_wdata;
	cache_entry_t ram_rdata;

	dcache_ctrl dcache_ctrl_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_cpu_req(i_cpu_req),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_bus_request(bus_request),
		.o_bus_req(bus_req),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata),
		.o_ram_write(ram_write),
		.o_ram_index(ram_index),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata)
	);

	line_ram #(
		.T(cache_entry_t),
		.DEPTH(CACHE_LINES)
	) cache_ram_i (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_index(ram_index),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	main_memory main_memory_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(bus_request),
		.i_bus_req(bus_req),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata)
	);

endmodule

/* tests/dcache_tb.sv */
module dcache_tb;

	timeunit 1ns;
	timeprecision 1ns;

	import dcache_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int DIRECTED_REQUESTS = 21;
	localparam int RANDOM_REQUESTS = 200;
	localparam int TOTAL_REQUESTS = DIRECTED_REQUESTS + RANDOM_REQUESTS;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_REQUESTS + RESET_CYCLES + CACHE_LINES + 1;
	localparam int MEM_WORDS = 1 << MEM_ADDR_BITS;

	logic i_clock;
	logic i_reset;
	logic i_request;
	cpu_req_t i_cpu_req;
	logic o_ready;
	logic [31:0] o_rdata;

	// Memory as the CPU sees it.
	logic [31:0] ref_mem [MEM_WORDS];
	logic written [MEM_WORDS];

	logic check_read;
	logic [31:0] exp_data;
	logic [31:0] exp_address;
	logic [31:0] lcg_state;
	logic [5:0] init_count;
	int cycle_count;
	int request_count;
	int data_errors;
	int protocol_errors;

	dcache_top dcache_top_i (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_cpu_req(i_cpu_req),
		.o_ready(o_ready),
		.o_rdata(o_rdata)
	);

	always #50 i_clock = ~i_clock;

	// Saturating count of cycles since reset was released.
	always @(posedge i_clock) begin
		if (i_reset)
			init_count <= '0;
		else if (init_count != '1)
			init_count <= init_count + 1'b1;
	end

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: only %0d of %0d requests finished within %0d cycles",
				request_count, TOTAL_REQUESTS, cycle_count);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic count_mismatch(input logic [31:0] address, input logic [31:0] got,
		input logic [31:0] expected);
		$display("ERR %0t: read at %h returned %h, expected %h", $time, address, got, expected);
		data_errors++;
	endtask

	task automatic note_violation(input string what);
		$display("At %0t the CPU handshake broke: %s", $time, what);
		protocol_errors++;
	endtask

	// ======================================================================
	// Checks
	// ======================================================================

	a_init_quiet: assert property (@(posedge i_clock) disable iff (i_reset)
		(init_count <= CACHE_LINES) |-> !o_ready)
		else note_violation("o_ready came up while the cache was still initializing");

	a_ready_with_request: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |-> i_request)
		else note_violation("o_ready came up with no request pending");

	a_ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready |=> !o_ready)
		else note_violation("o_ready stayed high for more than one cycle");

	a_read_data: assert property (@(posedge i_clock) disable iff (i_reset)
		o_ready && check_read |-> o_rdata == exp_data)
		else count_mismatch($sampled(exp_address), $sampled(o_rdata), $sampled(exp_data));

	// ======================================================================
	// Stimulus helpers
	// ======================================================================

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_below(input int limit);
		return int'((next_random() >> 16) % limit);
	endfunction

	function automatic cpu_req_t build_request(input logic rw, input logic flush,
		input logic cacheable, input int word, input logic [31:0] wdata);
		cpu_req_t req;
		req.rw = rw;
		req.flush = flush;
		req.cacheable = cacheable;
		req.address = word << 2;
		req.wdata = wdata;
		return req;
	endfunction

	// One full handshake. The reference is updated as the write is issued.
	task automatic issue_request(input cpu_req_t req);
		int word;
		word = int'(req.address[MEM_ADDR_BITS+1:2]);
		@(posedge i_clock);
		i_cpu_req <= req;
		i_request <= 1'b1;
		check_read <= !req.rw && !req.flush;
		exp_data <= ref_mem[word];
		exp_address <= req.address;
		if (req.rw && !req.flush) begin
			ref_mem[word] = req.wdata;
			written[word] = 1'b1;
		end
		@(posedge i_clock);
		while (!o_ready) begin
			@(posedge i_clock);
		end
		i_request <= 1'b0;
		check_read <= 1'b0;
		request_count++;
	endtask

	// ======================================================================
	// Directed sequences
	// ======================================================================

	task automatic write_then_read();
		issue_request(build_request(1'b1, 1'b0, 1'b1, 3, next_random()));
		issue_request(build_request(1'b0, 1'b0, 1'b1, 3, '0));
		// The same line again is served from the entry already on the RAM port.
		issue_request(build_request(1'b0, 1'b0, 1'b1, 3, '0));
		issue_request(build_request(1'b1, 1'b0, 1'b1, 21, next_random()));
		issue_request(build_request(1'b0, 1'b0, 1'b1, 21, '0));
	endtask

	// Words 7 and 55 share line 7.
	task automatic index_conflict();
		issue_request(build_request(1'b1, 1'b0, 1'b1, 7, next_random()));
		issue_request(build_request(1'b1, 1'b0, 1'b1, 55, next_random()));
		issue_request(build_request(1'b0, 1'b0, 1'b1, 7, '0));
		issue_request(build_request(1'b0, 1'b0, 1'b1, 55, '0));
	endtask

	task automatic pass_through_access();
		issue_request(build_request(1'b1, 1'b0, 1'b0, 240, next_random()));
		issue_request(build_request(1'b0, 1'b0, 1'b0, 240, '0));
		issue_request(build_request(1'b0, 1'b0, 1'b1, 240, '0));
	endtask

	task automatic flush_and_verify();
		int words [4] = '{8, 9, 26, 43};
		foreach (words[n])
			issue_request(build_request(1'b1, 1'b0, 1'b1, words[n], next_random()));
		issue_request(build_request(1'b0, 1'b1, 1'b1, 0, '0));
		// Memory itself must now hold the dirty data.
		foreach (words[n])
			issue_request(build_request(1'b0, 1'b0, 1'b0, words[n], '0));
	endtask

	// ======================================================================
	// Random mix
	// ======================================================================

	task automatic random_mix();
		int n;
		int sel;
		int word;
		logic write;
		for (n = 0; n < RANDOM_REQUESTS; n++) begin
			sel = rand_below(32);
			if (sel == 0) begin
				issue_request(build_request(1'b0, 1'b1, 1'b1, 0, '0));
			end else if (sel < 5) begin
				// Uncacheable traffic keeps to words 128..191, which are never cached.
				word = 128 + rand_below(64);
				write = (sel < 3) || !written[word];
				issue_request(build_request(write, 1'b0, 1'b0, word, next_random()));
			end else begin
				// Eight tags over eight lines make misses evict often.
				word = 16 * rand_below(8) + rand_below(8);
				write = rand_below(2) == 1 || !written[word];
				issue_request(build_request(write, 1'b0, 1'b1, word, next_random()));
			end
		end
	endtask

	initial begin
		int i;
		lcg_state = 32'd78456;
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_cpu_req = '0;
		check_read = 1'b0;
		exp_data = '0;
		exp_address = '0;
		cycle_count = 0;
		request_count = 0;
		data_errors = 0;
		protocol_errors = 0;
		for (i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
			written[i] = 1'b0;
		end

		repeat (RESET_CYCLES) @(posedge i_clock);
		i_reset <= 1'b0;

		// The first request is raised while initialization still runs.
		write_then_read();
		index_conflict();
		pass_through_access();
		flush_and_verify();
		random_mix();
		repeat (2) @(posedge i_clock);

		$display("Requests: %0d, data errors: %0d, protocol errors: %0d",
			request_count, data_errors, protocol_errors);
		if (data_errors == 0 && protocol_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* filelist.f */
hdl/dcache_pkg.sv
hdl/line_ram.sv
hdl/dcache_ctrl.sv
hdl/main_memory.sv
hdl/dcache_top.sv
tests/dcache_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= dcache_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
